/* rename_core.f */
+incdir+bench
verilog/rename_pkg.sv
verilog/instr_decode.sv
verilog/reg_rename.sv
verilog/reorder_buffer.sv
verilog/rename_core_top.sv
bench/rename_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rename core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f rename_core.f --top-module rename_core_tb -o rename_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/rename_core_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

/* bench/rename_model.svh */
`ifndef rename_model_svh
`define rename_model_svh

// One retired instruction as the core should report it
typedef struct packed {
  logic [gpr_idx_size-1:0] dst;
  logic [gpr_size-1:0]     value;
  logic                    set;
  nzcv_t                   nzcv;
} expected_commit_t;

// Architectural state, updated in program order
logic [gpr_size-1:0] model_gpr [gpr_count];
nzcv_t               model_flags;
expected_commit_t    exp_q [$];

// Front of the queue, held steady between rising edges
logic                    exp_present;
logic [gpr_idx_size-1:0] exp_reg;
logic [gpr_size-1:0]     exp_value;
logic                    exp_set;
nzcv_t                   exp_nzcv;

function automatic void clear_model();
  for (int r = 0; r < gpr_count; r++) begin
    model_gpr[r] = '0;
  end
  model_flags = '0;
  exp_q.delete();
endfunction

// Result and flags worked out from the instruction set rules
function automatic void golden_alu(
  input  opcode_t             op,
  input  logic [gpr_size-1:0] a,
  input  logic [gpr_size-1:0] b,
  input  logic                cin,
  output logic [gpr_size-1:0] res,
  output nzcv_t               f
);
  logic [gpr_size:0] wide;
  logic              carry;
  longint            sa;
  longint            sb;
  longint            sr;
  sa = $signed(a);
  sb = $signed(b);
  sr = 0;
  f = '0;
  carry = (op == op_adc) ? cin : 1'b0;
  case (op)
    op_add, op_addi, op_adc: begin
      wide = {1'b0, a} + {1'b0, b} + {{gpr_size{1'b0}}, carry};
      sr = sa + sb + longint'(carry);
      res = wide[gpr_size-1:0];
      f.c = wide[gpr_size];
    end
    op_sub, op_subi: begin
      res = a - b;
      sr = sa - sb;
      // No borrow when a is not below b
      f.c = (a >= b);
    end
    op_and: res = a & b;
    op_orr: res = a | b;
    default: res = b;
  endcase
  // Exact signed result outside the 32-bit range
  f.v = (sr > 64'sd2147483647) || (sr < -64'sd2147483648);
  f.n = res[gpr_size-1];
  f.z = (res == '0);
endfunction

// Executes one accepted word and queues its commit
function automatic void run_reference(input instr_word_t word);
  expected_commit_t e;
  opcode_t          op;
  logic             use_imm;
  logic [gpr_size-1:0] a;
  logic [gpr_size-1:0] b;
  op = word.r.opcode;
  use_imm = (op == op_addi) || (op == op_subi) || (op == op_movi);
  a = model_gpr[word.r.src1];
  b = use_imm ? {{(gpr_size-imm_size){1'b0}}, word.i.imm} : model_gpr[word.r.src2];
  golden_alu(op, a, b, model_flags.c, e.value, e.nzcv);
  e.dst = word.r.dst;
  e.set = word.r.set_flags;
  if (e.set) begin
    model_flags = e.nzcv;
  end
  // Register 15 stays zero, the commit is still expected
  if (e.dst != zero_reg) begin
    model_gpr[e.dst] = e.value;
  end
  exp_q.push_back(e);
endfunction

function automatic void load_front();
  if (exp_q.size() > 0) begin
    exp_present = 1'b1;
    exp_reg = exp_q[0].dst;
    exp_value = exp_q[0].value;
    exp_set = exp_q[0].set;
    exp_nzcv = exp_q[0].nzcv;
  end else begin
    exp_present = 1'b0;
  end
endfunction

`endif

/* bench/rename_core_tb.sv */
`timescale 1ns/1ps

module rename_core_tb import rename_pkg::*; ();

  // Run length, used by the watchdog
  localparam int clk_period = 100;
  localparam int reset_reads = 16;
  localparam int directed_len = 14;
  localparam int burst_len = 12;
  localparam int random_len = 300;
  localparam int instr_total = reset_reads + directed_len + burst_len + random_len;
  localparam int watchdog_cycles = (instr_total + 50) * 20;

  logic                    in_clk = 1'b0;
  logic                    in_rst;
  logic                    instr_valid;
  instr_word_t             instr_word;
  logic                    instr_ready;
  logic                    commit_valid;
  logic [gpr_idx_size-1:0] commit_reg;
  logic [gpr_size-1:0]     commit_value;
  logic                    commit_set_nzcv;
  nzcv_t                   commit_nzcv;

  int check_errors = 0;
  int end_errors = 0;
  int commit_count;
  int accepted_count;

  `include "rename_model.svh"

  rename_core_top i_dut (.*);

  always #(clk_period / 2) in_clk = ~in_clk;

  // Acceptance and retirement seen on the same edge as the DUT
  always @(posedge in_clk) begin
    if (in_rst) begin
      clear_model();
      commit_count = 0;
      accepted_count = 0;
    end else begin
      if (commit_valid) begin
        commit_count++;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (instr_valid && instr_ready) begin
        accepted_count++;
        run_reference(instr_word);
      end
    end
    load_front();
  end

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("ERR %0t ns %s expected 0x%h got 0x%h", $time, name, expected, actual);
    check_errors++;
  endtask

  // Commit checks on the falling edge, outputs and queue front both stable
  commit_has_match: assert property (@(negedge in_clk) disable iff (in_rst)
    commit_valid |-> exp_present)
    else begin
      $display("Commit at %0t ns with no accepted instruction left to retire", $time);
      check_errors++;
    end
  commit_reg_ok: assert property (@(negedge in_clk) disable iff (in_rst)
    commit_valid && exp_present |-> commit_reg == exp_reg)
    else report_value("commit_reg", {28'd0, exp_reg}, {28'd0, commit_reg});
  commit_value_ok: assert property (@(negedge in_clk) disable iff (in_rst)
    commit_valid && exp_present |-> commit_value == exp_value)
    else report_value("commit_value", exp_value, commit_value);
  commit_set_ok: assert property (@(negedge in_clk) disable iff (in_rst)
    commit_valid && exp_present |-> commit_set_nzcv == exp_set)
    else report_value("commit_set_nzcv", {31'd0, exp_set}, {31'd0, commit_set_nzcv});
  // Flags only matter on flag-setting commits
  commit_nzcv_ok: assert property (@(negedge in_clk) disable iff (in_rst)
    commit_valid && exp_present && exp_set |-> commit_nzcv == exp_nzcv)
    else report_value("commit_nzcv", {28'd0, exp_nzcv}, {28'd0, commit_nzcv});

  function automatic instr_word_t reg_form(input opcode_t op, input logic sf,
    input logic [3:0] dst, input logic [3:0] s1, input logic [3:0] s2);
    instr_word_t w;
    w = '0;
    w.r.opcode = op;
    w.r.set_flags = sf;
    w.r.dst = dst;
    w.r.src1 = s1;
    w.r.src2 = s2;
    return w;
  endfunction

  function automatic instr_word_t imm_form(input opcode_t op, input logic sf,
    input logic [3:0] dst, input logic [3:0] s1, input logic [15:0] imm);
    instr_word_t w;
    w = '0;
    w.i.opcode = op;
    w.i.set_flags = sf;
    w.i.dst = dst;
    w.i.src1 = s1;
    w.i.imm = imm;
    return w;
  endfunction

  // Small register pool keeps dependencies dense
  function automatic logic [gpr_idx_size-1:0] pick_reg();
    int unsigned r;
    r = $urandom_range(6, 0);
    if (r == 6) begin
      return zero_reg;
    end
    return r[gpr_idx_size-1:0];
  endfunction

  function automatic instr_word_t random_instr();
    opcode_t op;
    logic    sf;
    op = opcode_t'(4'($urandom_range(7, 0)));
    sf = ($urandom_range(1, 0) == 1);
    if (op == op_addi || op == op_subi || op == op_movi) begin
      return imm_form(op, sf, pick_reg(), pick_reg(), 16'($urandom));
    end
    return reg_form(op, sf, pick_reg(), pick_reg(), pick_reg());
  endfunction

  // Called on a falling edge, holds the word until it is taken
  task automatic send_instr(input instr_word_t word);
    instr_valid = 1'b1;
    instr_word = word;
    // Ready only moves on rising edges
    while (!instr_ready) begin
      @(negedge in_clk);
    end
    @(negedge in_clk);
    instr_valid = 1'b0;
  endtask

  task automatic print_summary();
    $display("Errors: %0d commit checks, %0d end checks; %0d of %0d accepted committed",
             check_errors, end_errors, commit_count, accepted_count);
  endtask

  initial begin
    in_rst = 1'b1;
    instr_valid = 1'b0;
    instr_word = '0;
    void'($urandom(1118));
    repeat (2) @(negedge in_clk);
    in_rst = 1'b0;

    // Idle state straight out of reset
    assert (commit_valid == 1'b0 && instr_ready == 1'b1) else begin
      $display("After reset commit_valid is not low or instr_ready is not high");
      end_errors++;
    end

    // Every register reads zero after reset
    for (int r = 0; r < reset_reads; r++) begin
      send_instr(reg_form(op_orr, 1'b0, 4'(r), 4'(r), zero_reg));
    end

    // Dependency chains, flags and writes to register 15
    send_instr(imm_form(op_movi, 1'b0, 4'd1, 4'd0, 16'h1234));
    send_instr(imm_form(op_movi, 1'b0, 4'd2, 4'd0, 16'hffff));
    send_instr(reg_form(op_add, 1'b0, 4'd3, 4'd1, 4'd2));
    send_instr(reg_form(op_sub, 1'b0, 4'd4, 4'd3, 4'd1));
    send_instr(reg_form(op_and, 1'b0, 4'd5, 4'd3, 4'd2));
    send_instr(reg_form(op_orr, 1'b0, 4'd0, 4'd4, 4'd5));
    send_instr(imm_form(op_addi, 1'b0, 4'd1, 4'd1, 16'h0001));
    // Borrow, then a carry out of bit 31
    send_instr(imm_form(op_subi, 1'b1, 4'd3, zero_reg, 16'h0001));
    send_instr(imm_form(op_addi, 1'b1, 4'd3, 4'd3, 16'h0001));
    send_instr(reg_form(op_adc, 1'b0, 4'd4, zero_reg, zero_reg));
    send_instr(reg_form(op_add, 1'b0, 4'd4, 4'd4, 4'd4));
    send_instr(reg_form(op_adc, 1'b1, 4'd5, 4'd4, 4'd4));
    send_instr(imm_form(op_movi, 1'b0, zero_reg, 4'd0, 16'h0055));
    send_instr(reg_form(op_add, 1'b0, 4'd0, zero_reg, zero_reg));

    // Back-to-back burst, no idle cycles
    for (int i = 0; i < burst_len; i++) begin
      send_instr(reg_form((i % 2 == 1) ? op_adc : op_sub, 1'b1, 4'(i % 4),
                          4'((i + 1) % 4), 4'(i % 4)));
    end

    for (int n = 0; n < random_len; n++) begin
      repeat ($urandom_range(3, 0)) @(negedge in_clk);
      send_instr(random_instr());
    end

    // Drain, then look for stray commits
    while (commit_count != accepted_count) begin
      @(negedge in_clk);
    end
    repeat (8) @(negedge in_clk);

    assert (commit_count == accepted_count && exp_q.size() == 0) else begin
      $display("Commit count %0d does not match %0d accepted instructions",
               commit_count, accepted_count);
      end_errors++;
    end

    print_summary();
    if (check_errors == 0 && end_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout after %0d cycles, the core stopped committing", watchdog_cycles);
    print_summary();
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* verilog/rename_core_top.sv */
`timescale 1ns/1ps

module rename_core_top import rename_pkg::*; (
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    instr_valid,
  input  instr_word_t             instr_word,
  output logic                    instr_ready,
  output logic                    commit_valid,
  output logic [gpr_idx_size-1:0] commit_reg,
  output logic [gpr_size-1:0]     commit_value,
  output logic                    commit_set_nzcv,
  output nzcv_t                   commit_nzcv
);

  // Decode to rename
  logic                    dec_valid;
  opcode_t                 dec_opcode;
  logic                    dec_set_flags;
  logic                    dec_use_imm;
  logic [imm_size-1:0]     dec_imm;
  logic [gpr_idx_size-1:0] dec_src1;
  logic [gpr_idx_size-1:0] dec_src2;
  logic [gpr_idx_size-1:0] dec_dst;

  // Rename to reorder buffer
  logic                    disp_valid;
  opcode_t                 disp_opcode;
  logic                    disp_set_flags;
  logic [gpr_idx_size-1:0] disp_dst;
  logic                    disp_src1_valid;
  logic [gpr_size-1:0]     disp_src1_value;
  logic [rob_idx_size-1:0] disp_src1_tag;
  logic                    disp_src2_valid;
  logic [gpr_size-1:0]     disp_src2_value;
  logic [rob_idx_size-1:0] disp_src2_tag;
  logic                    disp_nzcv_valid;
  nzcv_t                   disp_nzcv;
  logic [rob_idx_size-1:0] disp_nzcv_tag;

  // Reorder buffer feedback
  logic                    rob_space;
  logic [rob_idx_size-1:0] alloc_tag;
  logic [rob_idx_size-1:0] commit_tag;

  // Port names match the nets above
  instr_decode i_decode (.*);

  reg_rename i_rename (.*);

  reorder_buffer i_rob (.*);

endmodule

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer import rename_pkg::*; (
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    disp_valid,
  input  opcode_t                 disp_opcode,
  input  logic                    disp_set_flags,
  input  logic [gpr_idx_size-1:0] disp_dst,
  input  logic                    disp_src1_valid,
  input  logic [gpr_size-1:0]     disp_src1_value,
  input  logic [rob_idx_size-1:0] disp_src1_tag,
  input  logic                    disp_src2_valid,
  input  logic [gpr_size-1:0]     disp_src2_value,
  input  logic [rob_idx_size-1:0] disp_src2_tag,
  input  logic                    disp_nzcv_valid,
  input  nzcv_t                   disp_nzcv,
  input  logic [rob_idx_size-1:0] disp_nzcv_tag,
  output logic                    rob_space,
  output logic [rob_idx_size-1:0] alloc_tag,
  output logic                    commit_valid,
  output logic [gpr_idx_size-1:0] commit_reg,
  output logic [gpr_size-1:0]     commit_value,
  output logic [rob_idx_size-1:0] commit_tag,
  output logic                    commit_set_nzcv,
  output nzcv_t                   commit_nzcv
);

  // Entry fields
  opcode_t                 e_opcode [rob_count];
  logic                    e_set_flags [rob_count];
  logic [gpr_idx_size-1:0] e_dst [rob_count];
  logic                    e_src1_valid [rob_count];
  logic [gpr_size-1:0]     e_src1_value [rob_count];
  logic [rob_idx_size-1:0] e_src1_tag [rob_count];
  logic                    e_src2_valid [rob_count];
  logic [gpr_size-1:0]     e_src2_value [rob_count];
  logic [rob_idx_size-1:0] e_src2_tag [rob_count];
  logic                    e_nzcv_valid [rob_count];
  nzcv_t                   e_nzcv_in [rob_count];
  logic [rob_idx_size-1:0] e_nzcv_tag [rob_count];
  // Done stays set after commit until the slot is reused
  logic                    e_done [rob_count];
  logic [gpr_size-1:0]     e_result [rob_count];
  nzcv_t                   e_flags [rob_count];

  logic [rob_idx_size-1:0] head;
  logic [rob_idx_size-1:0] tail;
  logic [rob_idx_size:0]   count;
  logic                    do_commit;

  // Execute slot
  logic                    exec_fire;
  logic [rob_idx_size-1:0] exec_tag;
  logic [rob_idx_size-1:0] scan_idx;
  logic [gpr_size-1:0]     exec_result;
  nzcv_t                   exec_flags;

  // Operands of the entry being allocated
  logic                    alloc_src1_valid;
  logic [gpr_size-1:0]     alloc_src1_value;
  logic                    alloc_src2_valid;
  logic [gpr_size-1:0]     alloc_src2_value;
  logic                    alloc_nzcv_valid;
  nzcv_t                   alloc_nzcv;

  // Two instructions may sit in decode and rename
  assign rob_space = (count <= (rob_count - 3));
  // Entry in rename lands at tail on the next edge
  assign alloc_tag = tail + {{(rob_idx_size-1){1'b0}}, disp_valid};
  assign do_commit = (count != '0) && e_done[head];

  // Oldest ready entry, scanning from head
  always_comb begin
    exec_fire = 1'b0;
    exec_tag = head;
    scan_idx = head;
    for (int i = 0; i < rob_count; i++) begin
      scan_idx = head + i[rob_idx_size-1:0];
      if (!exec_fire && i < count && !e_done[scan_idx] &&
          e_src1_valid[scan_idx] && e_src2_valid[scan_idx] &&
          (e_nzcv_valid[scan_idx] || e_opcode[scan_idx] != op_adc)) begin
        exec_fire = 1'b1;
        exec_tag = scan_idx;
      end
    end
  end

  always_comb begin
    alu_compute(e_opcode[exec_tag], e_src1_value[exec_tag], e_src2_value[exec_tag],
                e_nzcv_in[exec_tag].c, exec_result, exec_flags);
  end

  // Waiting operand takes a result broadcast now or one already done
  function automatic void wake_operand(
    input  logic                    valid_in,
    input  logic [gpr_size-1:0]     value_in,
    input  logic [rob_idx_size-1:0] tag,
    output logic                    valid_out,
    output logic [gpr_size-1:0]     value_out
  );
    valid_out = 1'b1;
    if (valid_in) begin
      value_out = value_in;
    end else if (exec_fire && exec_tag == tag) begin
      value_out = exec_result;
    end else if (e_done[tag]) begin
      value_out = e_result[tag];
    end else begin
      valid_out = 1'b0;
      value_out = value_in;
    end
  endfunction

  always_comb begin
    wake_operand(disp_src1_valid, disp_src1_value, disp_src1_tag,
                 alloc_src1_valid, alloc_src1_value);
    wake_operand(disp_src2_valid, disp_src2_value, disp_src2_tag,
                 alloc_src2_valid, alloc_src2_value);
    // Flag tag always names a flag-setting entry
    alloc_nzcv_valid = 1'b1;
    if (disp_nzcv_valid) begin
      alloc_nzcv = disp_nzcv;
    end else if (exec_fire && e_set_flags[exec_tag] && exec_tag == disp_nzcv_tag) begin
      alloc_nzcv = exec_flags;
    end else if (e_done[disp_nzcv_tag]) begin
      alloc_nzcv = e_flags[disp_nzcv_tag];
    end else begin
      alloc_nzcv_valid = 1'b0;
      alloc_nzcv = disp_nzcv;
    end
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      commit_valid <= 1'b0;
      for (int k = 0; k < rob_count; k++) begin
        e_done[k] <= 1'b0;
      end
    end else begin
      commit_valid <= do_commit;
      if (do_commit) begin
        head <= head + 1'b1;
      end
      if (disp_valid) begin
        tail <= tail + 1'b1;
      end
      count <= count + (rob_idx_size+1)'(disp_valid) - (rob_idx_size+1)'(do_commit);
      if (exec_fire) begin
        e_done[exec_tag] <= 1'b1;
      end
      if (disp_valid) begin
        e_done[tail] <= 1'b0;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (do_commit) begin
      commit_reg <= e_dst[head];
      commit_value <= e_result[head];
      commit_tag <= head;
      commit_set_nzcv <= e_set_flags[head];
      commit_nzcv <= e_flags[head];
    end
    if (exec_fire) begin
      e_result[exec_tag] <= exec_result;
      e_flags[exec_tag] <= exec_flags;
      // Broadcast to every waiting operand
      for (int k = 0; k < rob_count; k++) begin
        if (!e_src1_valid[k] && e_src1_tag[k] == exec_tag) begin
          e_src1_valid[k] <= 1'b1;
          e_src1_value[k] <= exec_result;
        end
        if (!e_src2_valid[k] && e_src2_tag[k] == exec_tag) begin
          e_src2_valid[k] <= 1'b1;
          e_src2_value[k] <= exec_result;
        end
        if (e_set_flags[exec_tag] && !e_nzcv_valid[k] && e_nzcv_tag[k] == exec_tag) begin
          e_nzcv_valid[k] <= 1'b1;
          e_nzcv_in[k] <= exec_flags;
        end
      end
    end
    // Allocation last, tail slot is never in the broadcast set
    if (disp_valid) begin
      e_opcode[tail] <= disp_opcode;
      e_set_flags[tail] <= disp_set_flags;
      e_dst[tail] <= disp_dst;
      e_src1_valid[tail] <= alloc_src1_valid;
      e_src1_value[tail] <= alloc_src1_value;
      e_src1_tag[tail] <= disp_src1_tag;
      e_src2_valid[tail] <= alloc_src2_valid;
      e_src2_value[tail] <= alloc_src2_value;
      e_src2_tag[tail] <= disp_src2_tag;
      e_nzcv_valid[tail] <= alloc_nzcv_valid;
      e_nzcv_in[tail] <= alloc_nzcv;
      e_nzcv_tag[tail] <= disp_nzcv_tag;
    end
  end

endmodule

/* verilog/reg_rename.sv */
`timescale 1ns/1ps

module reg_rename import rename_pkg::*; (
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    dec_valid,
  input  opcode_t                 dec_opcode,
  input  logic                    dec_set_flags,
  input  logic                    dec_use_imm,
  input  logic [imm_size-1:0]     dec_imm,
  input  logic [gpr_idx_size-1:0] dec_src1,
  input  logic [gpr_idx_size-1:0] dec_src2,
  input  logic [gpr_idx_size-1:0] dec_dst,
  input  logic [rob_idx_size-1:0] alloc_tag,
  input  logic                    commit_valid,
  input  logic [gpr_idx_size-1:0] commit_reg,
  input  logic [gpr_size-1:0]     commit_value,
  input  logic [rob_idx_size-1:0] commit_tag,
  input  logic                    commit_set_nzcv,
  input  nzcv_t                   commit_nzcv,
  output logic                    disp_valid,
  output opcode_t                 disp_opcode,
  output logic                    disp_set_flags,
  output logic [gpr_idx_size-1:0] disp_dst,
  output logic                    disp_src1_valid,
  output logic [gpr_size-1:0]     disp_src1_value,
  output logic [rob_idx_size-1:0] disp_src1_tag,
  output logic                    disp_src2_valid,
  output logic [gpr_size-1:0]     disp_src2_value,
  output logic [rob_idx_size-1:0] disp_src2_tag,
  output logic                    disp_nzcv_valid,
  output nzcv_t                   disp_nzcv,
  output logic [rob_idx_size-1:0] disp_nzcv_tag
);

  // Per register value, valid bit and producer tag
  logic [gpr_size-1:0]     gpr_value [gpr_count];
  logic                    gpr_valid [gpr_count];
  logic [rob_idx_size-1:0] gpr_tag [gpr_count];
  // Flags tracked like one more register
  nzcv_t                   flags;
  logic                    flags_valid;
  logic [rob_idx_size-1:0] flags_tag;

  // Read ports, 0 is src1 and 1 is src2
  logic [gpr_idx_size-1:0] rd_idx [2];
  logic                    rd_valid [2];
  logic [gpr_size-1:0]     rd_value [2];
  logic                    rd_flags_valid;
  nzcv_t                   rd_flags;

  assign rd_idx[0] = dec_src1;
  assign rd_idx[1] = dec_src2;

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      if (rd_idx[p] == zero_reg) begin
        rd_valid[p] = 1'b1;
        rd_value[p] = '0;
      end else if (gpr_valid[rd_idx[p]]) begin
        rd_valid[p] = 1'b1;
        rd_value[p] = gpr_value[rd_idx[p]];
      end else if (commit_valid && commit_reg == rd_idx[p] &&
                   commit_tag == gpr_tag[rd_idx[p]]) begin
        // Producer commits on this edge, bypass it
        rd_valid[p] = 1'b1;
        rd_value[p] = commit_value;
      end else begin
        rd_valid[p] = 1'b0;
        rd_value[p] = gpr_value[rd_idx[p]];
      end
    end
    // Same bypass for the flags
    if (!flags_valid && commit_valid && commit_set_nzcv && commit_tag == flags_tag) begin
      rd_flags_valid = 1'b1;
      rd_flags = commit_nzcv;
    end else begin
      rd_flags_valid = flags_valid;
      rd_flags = flags;
    end
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      disp_valid <= 1'b0;
      flags <= '0;
      flags_valid <= 1'b1;
      flags_tag <= '0;
      for (int r = 0; r < gpr_count; r++) begin
        gpr_value[r] <= '0;
        gpr_valid[r] <= 1'b1;
        gpr_tag[r] <= '0;
      end
    end else begin
      disp_valid <= dec_valid;
      // Commit only lands if no younger writer renamed the register
      if (commit_valid && commit_reg != zero_reg && commit_tag == gpr_tag[commit_reg]) begin
        gpr_value[commit_reg] <= commit_value;
        gpr_valid[commit_reg] <= 1'b1;
      end
      if (commit_valid && commit_set_nzcv && commit_tag == flags_tag) begin
        flags <= commit_nzcv;
        flags_valid <= 1'b1;
      end
      // Dispatch comes last so a new tag stays busy
      if (dec_valid && dec_dst != zero_reg) begin
        gpr_valid[dec_dst] <= 1'b0;
        gpr_tag[dec_dst] <= alloc_tag;
      end
      if (dec_valid && dec_set_flags) begin
        flags_valid <= 1'b0;
        flags_tag <= alloc_tag;
      end
    end
  end

  // Sources read from pre-edge state, before own dst goes busy
  always_ff @(posedge in_clk) begin
    if (dec_valid) begin
      disp_opcode <= dec_opcode;
      disp_set_flags <= dec_set_flags;
      disp_dst <= dec_dst;
      disp_src1_valid <= rd_valid[0];
      disp_src1_value <= rd_value[0];
      disp_src1_tag <= gpr_tag[dec_src1];
      disp_src2_valid <= dec_use_imm || rd_valid[1];
      disp_src2_value <= dec_use_imm ? {{(gpr_size-imm_size){1'b0}}, dec_imm} : rd_value[1];
      disp_src2_tag <= gpr_tag[dec_src2];
      disp_nzcv_valid <= rd_flags_valid;
      disp_nzcv <= rd_flags;
      disp_nzcv_tag <= flags_tag;
    end
  end

endmodule

/* verilog/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode import rename_pkg::*; (
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    instr_valid,
  input  instr_word_t             instr_word,
  input  logic                    rob_space,
  output logic                    instr_ready,
  output logic                    dec_valid,
  output opcode_t                 dec_opcode,
  output logic                    dec_set_flags,
  output logic                    dec_use_imm,
  output logic [imm_size-1:0]     dec_imm,
  output logic [gpr_idx_size-1:0] dec_src1,
  output logic [gpr_idx_size-1:0] dec_src2,
  output logic [gpr_idx_size-1:0] dec_dst
);

  logic accept;
  logic word_use_imm;
  logic word_is_movi;

  // Room downstream for everything in flight plus this word
  assign instr_ready = rob_space;
  assign accept = instr_valid && rob_space;

  // Opcode sits in the same bits for both forms
  always_comb begin
    case (instr_word.r.opcode)
      op_addi, op_subi, op_movi: word_use_imm = 1'b1;
      default: word_use_imm = 1'b0;
    endcase
  end

  assign word_is_movi = (instr_word.r.opcode == op_movi);

  // One-cycle strobe per accepted word
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;
    end
  end

  always_ff @(posedge in_clk) begin
    if (accept) begin
      dec_opcode <= instr_word.r.opcode;
      dec_set_flags <= instr_word.r.set_flags;
      dec_use_imm <= word_use_imm;
      dec_dst <= instr_word.r.dst;
      // MOVI adds imm to a zero that is always valid
      dec_src1 <= word_is_movi ? zero_reg : instr_word.r.src1;
      // Both views kept, rename picks one by dec_use_imm
      dec_src2 <= instr_word.r.src2;
      dec_imm <= instr_word.i.imm;
    end
  end

endmodule

/* verilog/rename_pkg.sv */
package rename_pkg;

  // Register file geometry
  localparam int gpr_count = 16;
  localparam int gpr_idx_size = 4;
  localparam int gpr_size = 32;
  // Always reads zero, never renamed
  localparam logic [gpr_idx_size-1:0] zero_reg = 4'd15;

  // Reorder buffer geometry
  localparam int rob_count = 8;
  localparam int rob_idx_size = 3;

  // Immediates are zero-extended
  localparam int imm_size = 16;

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_orr  = 4'd3,
    op_adc  = 4'd4,
    op_addi = 4'd5,
    op_subi = 4'd6,
    op_movi = 4'd7
  } opcode_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // Register form, three register fields
  typedef struct packed {
    opcode_t                 opcode;
    logic                    set_flags;
    logic [gpr_idx_size-1:0] dst;
    logic [gpr_idx_size-1:0] src1;
    logic [gpr_idx_size-1:0] src2;
    logic [14:0]             unused;
  } instr_r_t;

  // Immediate form, imm replaces src2
  typedef struct packed {
    opcode_t                 opcode;
    logic                    set_flags;
    logic [gpr_idx_size-1:0] dst;
    logic [gpr_idx_size-1:0] src1;
    logic [2:0]              unused;
    logic [imm_size-1:0]     imm;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_word_t;

  // Single-cycle ALU, result plus NZCV
  function automatic void alu_compute(
    input  opcode_t             op,
    input  logic [gpr_size-1:0] a,
    input  logic [gpr_size-1:0] b,
    input  logic                carry_in,
    output logic [gpr_size-1:0] result,
    output nzcv_t               flags
  );
    logic [gpr_size:0] sum;
    logic is_sub;
    logic is_arith;
    is_sub = (op == op_sub) || (op == op_subi);
    is_arith = (op == op_add) || (op == op_addi) || (op == op_adc) || is_sub;
    case (op)
      op_add, op_addi: sum = {1'b0, a} + {1'b0, b};
      op_adc: sum = {1'b0, a} + {1'b0, b} + {{gpr_size{1'b0}}, carry_in};
      // Two's complement, carry out means no borrow
      op_sub, op_subi: sum = {1'b0, a} + {1'b0, ~b} + {{gpr_size{1'b0}}, 1'b1};
      op_and: sum = {1'b0, a & b};
      op_orr: sum = {1'b0, a | b};
      default: sum = {1'b0, b};
    endcase
    result = sum[gpr_size-1:0];
    flags.n = result[gpr_size-1];
    flags.z = (result == '0);
    flags.c = is_arith ? sum[gpr_size] : 1'b0;
    // Signed overflow, operand signs flip for subtract
    if (!is_arith) begin
      flags.v = 1'b0;
    end else if (is_sub) begin
      flags.v = (a[gpr_size-1] != b[gpr_size-1]) && (result[gpr_size-1] != a[gpr_size-1]);
    end else begin
      flags.v = (a[gpr_size-1] == b[gpr_size-1]) && (result[gpr_size-1] != a[gpr_size-1]);
    end
  endfunction

endpackage
